//--- logic/pitaya_pkg.sv
//////////////////////////////////////////////////
// Shared widths and constants of the board top
// System bus opcode and region enums
// Command, decoded command and response structs
//////////////////////////////////////////////////

`default_nettype none

package pitaya_pkg;

  // System bus widths
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned DATA_W   = 32;
  // Address split into 16 regions of 4096 words
  localparam int unsigned REGION_W = 4;
  localparam int unsigned OFFSET_W = ADDR_W - REGION_W;

  // Analog sample widths
  localparam int unsigned ADC_W = 16;
  localparam int unsigned DAC_W = 14;

  // PDM level width and fixed modulator range
  localparam int unsigned PDM_W     = 8;
  localparam int unsigned PDM_RANGE = 255;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // Kept regions, all other numbers unmapped
  typedef enum logic [REGION_W-1:0] {
    REG_ID  = 4'd0,
    REG_PDM = 4'd1,
    REG_DAC = 4'd4,
    REG_ADC = 4'd8
  } region_e;

  // Host command as issued on the bus
  typedef struct packed {
    bus_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_cmd_t;

  // Command after region and offset split
  typedef struct packed {
    bus_op_e             op;
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
    logic [DATA_W-1:0]   wdata;
  } dec_cmd_t;

  typedef struct packed {
    bus_op_e           op;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  typedef logic signed [ADC_W-1:0] adc_sample_t;
  typedef logic signed [DAC_W-1:0] dac_sample_t;
  typedef logic        [PDM_W-1:0] pdm_level_t;

endpackage

`default_nettype wire

//--- logic/bus_decode.sv
//////////////////////////////////////////////////
// Command FIFO with credit return to the host
// Region and offset split of the bus address
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module bus_decode import pitaya_pkg::*; #(
  parameter int unsigned CMD_CREDITS = 2
) (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  logic     cmd_valid_i,
  input  bus_cmd_t cmd_i,
  output logic     credit_o,
  output logic     dec_valid_o,
  output dec_cmd_t dec_cmd_o
);

  localparam int unsigned PTR_W = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
  localparam int unsigned CNT_W = $clog2(CMD_CREDITS + 1);

  bus_cmd_t         fifo_mem [CMD_CREDITS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill_cnt;
  logic             pop;
  bus_cmd_t         head;

  // Downstream never stalls, drain one entry per cycle
  assign pop  = (fill_cnt != '0);
  assign head = fifo_mem[rd_ptr];

  //////////////////////////////////////////////////
  // FIFO control
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill_cnt    <= '0;
      credit_o    <= 1'b0;
      dec_valid_o <= 1'b0;
    end else begin
      // Host only sends while it holds a credit
      if (cmd_valid_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(CMD_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({cmd_valid_i, pop})
        2'b10:   fill_cnt <= fill_cnt + 1'b1;
        2'b01:   fill_cnt <= fill_cnt - 1'b1;
        default: fill_cnt <= fill_cnt;
      endcase
      // Each pop hands one credit back
      credit_o    <= pop;
      dec_valid_o <= pop;
    end
  end

  // Entry storage
  always_ff @(posedge adc_clk) begin
    if (cmd_valid_i) begin
      fifo_mem[wr_ptr] <= cmd_i;
    end
  end

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (pop) begin
      dec_cmd_o.op     <= head.op;
      // Upper bits select region, lower bits the word
      dec_cmd_o.region <= head.addr[ADDR_W-1 -: REGION_W];
      dec_cmd_o.offset <= head.addr[OFFSET_W-1:0];
      dec_cmd_o.wdata  <= head.wdata;
    end
  end

endmodule

`default_nettype wire

//--- logic/reg_execute.sv
//////////////////////////////////////////////////
// Register array for PDM levels and DAC samples
// Read data selection and access error detection
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module reg_execute import pitaya_pkg::*; #(
  parameter int unsigned       NUM_ADC  = 2,
  parameter int unsigned       NUM_DAC  = 2,
  parameter int unsigned       PDM_CHN  = 4,
  parameter logic [DATA_W-1:0] ID_VALUE = 32'h5250_0001
) (
  input  logic                      adc_clk,
  input  logic                      top_rst,
  input  logic                      dec_valid_i,
  input  dec_cmd_t                  dec_cmd_i,
  input  adc_sample_t [NUM_ADC-1:0] adc_word_i,
  output logic                      exe_valid_o,
  output bus_rsp_t                  exe_rsp_o,
  output pdm_level_t  [PDM_CHN-1:0] pdm_level_o,
  output dac_sample_t [NUM_DAC-1:0] dac_sample_o
);

  pdm_level_t  [PDM_CHN-1:0] pdm_q;
  dac_sample_t [NUM_DAC-1:0] dac_q;
  logic                      is_wr;
  logic                      err;
  logic [DATA_W-1:0]         rd_data;
  logic [PDM_CHN-1:0]        pdm_we;
  logic [NUM_DAC-1:0]        dac_we;

  assign is_wr = (dec_cmd_i.op == OP_WRITE);

  //////////////////////////////////////////////////
  // Read mux and error rule
  //////////////////////////////////////////////////

  always_comb begin
    err     = 1'b0;
    rd_data = '0;
    case (dec_cmd_i.region)
      // Single read-only ID word
      REG_ID: begin
        err     = is_wr || (dec_cmd_i.offset != '0);
        rd_data = ID_VALUE;
      end
      REG_PDM: begin
        err = (dec_cmd_i.offset >= PDM_CHN);
        for (int i = 0; i < PDM_CHN; i++) begin
          if (dec_cmd_i.offset == i) rd_data = {{(DATA_W-PDM_W){1'b0}}, pdm_q[i]};
        end
      end
      REG_DAC: begin
        err = (dec_cmd_i.offset >= NUM_DAC);
        for (int i = 0; i < NUM_DAC; i++) begin
          if (dec_cmd_i.offset == i) rd_data = {{(DATA_W-DAC_W){dac_q[i][DAC_W-1]}}, dac_q[i]};
        end
      end
      // ADC words are read only
      REG_ADC: begin
        err = is_wr || (dec_cmd_i.offset >= NUM_ADC);
        for (int i = 0; i < NUM_ADC; i++) begin
          if (dec_cmd_i.offset == i) begin
            rd_data = {{(DATA_W-ADC_W){adc_word_i[i][ADC_W-1]}}, adc_word_i[i]};
          end
        end
      end
      default: err = 1'b1;
    endcase
    // Errors return zero data
    if (err) rd_data = '0;
  end

  // Per-register write strobes
  always_comb begin
    for (int i = 0; i < PDM_CHN; i++) begin
      pdm_we[i] = dec_valid_i && is_wr && !err && (dec_cmd_i.region == REG_PDM) &&
                  (dec_cmd_i.offset == i);
    end
    for (int i = 0; i < NUM_DAC; i++) begin
      dac_we[i] = dec_valid_i && is_wr && !err && (dec_cmd_i.region == REG_DAC) &&
                  (dec_cmd_i.offset == i);
    end
  end

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      pdm_q       <= '0;
      dac_q       <= '0;
      exe_valid_o <= 1'b0;
    end else begin
      exe_valid_o <= dec_valid_i;
      for (int i = 0; i < PDM_CHN; i++) begin
        if (pdm_we[i]) pdm_q[i] <= dec_cmd_i.wdata[PDM_W-1:0];
      end
      for (int i = 0; i < NUM_DAC; i++) begin
        if (dac_we[i]) dac_q[i] <= dec_cmd_i.wdata[DAC_W-1:0];
      end
    end
  end

  // Response payload
  always_ff @(posedge adc_clk) begin
    if (dec_valid_i) begin
      exe_rsp_o.op    <= dec_cmd_i.op;
      exe_rsp_o.err   <= err;
      exe_rsp_o.rdata <= rd_data;
    end
  end

  assign pdm_level_o  = pdm_q;
  assign dac_sample_o = dac_q;

endmodule

`default_nettype wire

//--- logic/bus_result.sv
//////////////////////////////////////////////////
// Response register stage toward the host
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module bus_result import pitaya_pkg::*; (
  input  logic     adc_clk,
  input  logic     top_rst,
  input  logic     exe_valid_i,
  input  bus_rsp_t exe_rsp_i,
  output logic     rsp_valid_o,
  output bus_rsp_t rsp_o
);

  // Host always accepts, no back-pressure here
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= exe_valid_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (exe_valid_i) begin
      rsp_o.op  <= exe_rsp_i.op;
      rsp_o.err <= exe_rsp_i.err;
      // Write responses carry status only
      rsp_o.rdata <= (exe_rsp_i.op == OP_READ) ? exe_rsp_i.rdata : '0;
    end
  end

endmodule

`default_nettype wire

//--- logic/analog_io.sv
//////////////////////////////////////////////////
// ADC input capture and two's complement convert
// DAC output register with negative slope format
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module analog_io import pitaya_pkg::*; #(
  parameter int unsigned NUM_ADC = 2,
  parameter int unsigned NUM_DAC = 2
) (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  logic        [NUM_ADC-1:0][ADC_W-1:0] adc_dat_i,
  output adc_sample_t [NUM_ADC-1:0]            adc_word_o,
  input  dac_sample_t [NUM_DAC-1:0]            dac_sample_i,
  output logic        [NUM_DAC-1:0][DAC_W-1:0] dac_dat_o
);

  logic [NUM_ADC-1:0][ADC_W-1:0] adc_raw;

  //////////////////////////////////////////////////
  // ADC
  //////////////////////////////////////////////////

  // Input register close to the pins
  always_ff @(posedge adc_clk) begin
    adc_raw <= adc_dat_i;
  end

  for (genvar i = 0; i < NUM_ADC; i++) begin : g_adc
    // Negative slope to two's complement
    assign adc_word_o[i] = {adc_raw[i][ADC_W-1], ~adc_raw[i][ADC_W-2:0]};
  end

  //////////////////////////////////////////////////
  // DAC
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_DAC; i++) begin : g_dac
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        // Midscale, same code as sample 0
        dac_dat_o[i] <= {1'b0, {(DAC_W-1){1'b1}}};
      end else begin
        dac_dat_o[i] <= {dac_sample_i[i][DAC_W-1], ~dac_sample_i[i][DAC_W-2:0]};
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pdm_mod.sv
//////////////////////////////////////////////////
// Multi-channel pulse-density modulators
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pdm_mod import pitaya_pkg::*; #(
  parameter int unsigned PDM_CHN = 4
) (
  input  logic                     adc_clk,
  input  logic                     top_rst,
  input  pdm_level_t [PDM_CHN-1:0] pdm_level_i,
  output logic       [PDM_CHN-1:0] pdm_o
);

  for (genvar i = 0; i < PDM_CHN; i++) begin : g_chn
    logic [PDM_W-1:0] acc;
    logic [PDM_W:0]   sum;

    // One extra bit so the sum never wraps
    assign sum = {1'b0, acc} + {1'b0, pdm_level_i[i]};

    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        acc      <= '0;
        pdm_o[i] <= 1'b0;
      end else if (sum >= (PDM_W+1)'(PDM_RANGE)) begin
        // Overflow of the range emits a one
        acc      <= PDM_W'(sum - (PDM_W+1)'(PDM_RANGE));
        pdm_o[i] <= 1'b1;
      end else begin
        acc      <= sum[PDM_W-1:0];
        pdm_o[i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pitaya_top.sv
//////////////////////////////////////////////////
// Board top level, register side and analog IO
// Bus decode, execute, response, ADC/DAC and PDM
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module pitaya_top import pitaya_pkg::*; #(
  parameter int unsigned       NUM_ADC     = 2,
  parameter int unsigned       NUM_DAC     = 2,
  parameter int unsigned       PDM_CHN     = 4,
  parameter int unsigned       CMD_CREDITS = 2,
  parameter logic [DATA_W-1:0] ID_VALUE    = 32'h5250_0001
) (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // Host command and response
  input  logic                          cmd_valid_i,
  input  bus_cmd_t                      cmd_i,
  output logic                          credit_o,
  output logic                          rsp_valid_o,
  output bus_rsp_t                      rsp_o,
  // Analog pins
  input  logic [NUM_ADC-1:0][ADC_W-1:0] adc_dat_i,
  output logic [NUM_DAC-1:0][DAC_W-1:0] dac_dat_o,
  output logic [PDM_CHN-1:0]            pdm_o
);

  logic                      dec_valid;
  dec_cmd_t                  dec_cmd;
  logic                      exe_valid;
  bus_rsp_t                  exe_rsp;
  pdm_level_t  [PDM_CHN-1:0] pdm_level;
  dac_sample_t [NUM_DAC-1:0] dac_sample;
  adc_sample_t [NUM_ADC-1:0] adc_word;

  //////////////////////////////////////////////////
  // System bus pipeline
  //////////////////////////////////////////////////

  bus_decode #(
    .CMD_CREDITS (CMD_CREDITS)
  ) u_bus_decode (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .credit_o    (credit_o),
    .dec_valid_o (dec_valid),
    .dec_cmd_o   (dec_cmd)
  );

  reg_execute #(
    .NUM_ADC  (NUM_ADC),
    .NUM_DAC  (NUM_DAC),
    .PDM_CHN  (PDM_CHN),
    .ID_VALUE (ID_VALUE)
  ) u_reg_execute (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .dec_valid_i  (dec_valid),
    .dec_cmd_i    (dec_cmd),
    .adc_word_i   (adc_word),
    .exe_valid_o  (exe_valid),
    .exe_rsp_o    (exe_rsp),
    .pdm_level_o  (pdm_level),
    .dac_sample_o (dac_sample)
  );

  bus_result u_bus_result (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .exe_valid_i (exe_valid),
    .exe_rsp_i   (exe_rsp),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

  //////////////////////////////////////////////////
  // Analog side
  //////////////////////////////////////////////////

  analog_io #(
    .NUM_ADC (NUM_ADC),
    .NUM_DAC (NUM_DAC)
  ) u_analog_io (
    .adc_clk      (adc_clk),
    .top_rst      (top_rst),
    .adc_dat_i    (adc_dat_i),
    .adc_word_o   (adc_word),
    .dac_sample_i (dac_sample),
    .dac_dat_o    (dac_dat_o)
  );

  // PDM outputs, one bit per channel per cycle
  pdm_mod #(
    .PDM_CHN (PDM_CHN)
  ) u_pdm_mod (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .pdm_level_i (pdm_level),
    .pdm_o       (pdm_o)
  );

endmodule

`default_nettype wire

//--- bench/tb_tasks.svh
//////////////////////////////////////////////////
// Host driver that waits for credits
// Value compare, expected data models
// Directed tests of the board top
//////////////////////////////////////////////////

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// Compare and report a mismatch
task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    errors++;
    $display("ERR %0t: %s mismatch, got %0h expected %0h", $time, what, got, exp);
  end
endtask

function automatic bus_rsp_t make_rsp(bus_op_e op, logic err, logic [DATA_W-1:0] rdata);
  bus_rsp_t rsp;
  rsp.op    = op;
  rsp.err   = err;
  rsp.rdata = rdata;
  return rsp;
endfunction

// ADC word, top bit kept and the rest inverted, then sign-extended
function automatic logic [DATA_W-1:0] adc_expect(logic [ADC_W-1:0] raw);
  logic [ADC_W-1:0] conv;
  conv = {raw[ADC_W-1], ~raw[ADC_W-2:0]};
  return {{(DATA_W-ADC_W){conv[ADC_W-1]}}, conv};
endfunction

// DAC pin code for a signed sample
function automatic logic [DAC_W-1:0] dac_expect(logic [DAC_W-1:0] smp);
  return {smp[DAC_W-1], ~smp[DAC_W-2:0]};
endfunction

//////////////////////////////////////////////////
// Host driver
//////////////////////////////////////////////////

// One command per edge, stalls while out of credits
task automatic send_cmd(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] wdata, input logic exp_err,
                        input logic [DATA_W-1:0] exp_rdata);
  bus_cmd_t cmd;
  cmd.op    = op;
  cmd.addr  = addr;
  cmd.wdata = wdata;
  @(posedge adc_clk);
  while (credits == 0) begin
    cmd_valid_i <= 1'b0;
    @(posedge adc_clk);
  end
  cmd_valid_i <= 1'b1;
  cmd_i       <= cmd;
  n_cmds++;
  exp_q.push_back(make_rsp(op, exp_err, exp_rdata));
endtask

// Stop sending and wait for every pending response
task automatic drain_rsp();
  int waited;
  waited = 0;
  @(posedge adc_clk);
  cmd_valid_i <= 1'b0;
  while (exp_q.size() != 0 && waited < 50) begin
    @(posedge adc_clk);
    waited++;
  end
  if (exp_q.size() != 0) begin
    errors++;
    $display("Responses missing: %0d commands got no answer in 50 cycles", exp_q.size());
    exp_q.delete();
    due_q.delete();
  end
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic reset_state_quiet();
  repeat (8) begin
    @(negedge adc_clk);
    check_val("credit_o idle", credit_o, 0);
    check_val("rsp_valid_o idle", rsp_valid_o, 0);
    check_val("pdm_o idle", pdm_o, 0);
    for (int i = 0; i < NUM_DAC; i++) begin
      check_val("dac_dat_o reset", dac_dat_o[i], 14'h1FFF);
    end
  end
endtask

task automatic id_and_error_reads();
  send_cmd(OP_READ, 16'h0000, '0, 1'b0, ID_VALUE);
  // Read-only ID, unmapped region, offset past the PDM channels
  send_cmd(OP_WRITE, 16'h0000, 32'h1234_5678, 1'b1, '0);
  send_cmd(OP_READ, 16'h5000, '0, 1'b1, '0);
  send_cmd(OP_READ, 16'h1004, '0, 1'b1, '0);
  drain_rsp();
endtask

// Latency and order are checked by the monitor
task automatic credit_burst_latency();
  for (int i = 0; i < CMD_CREDITS; i++) begin
    send_cmd(OP_READ, 16'h0000, '0, 1'b0, ID_VALUE);
  end
  drain_rsp();
  check_val("credit pulses", credit_cnt, n_cmds);
  check_val("host credits", credits, CMD_CREDITS);
endtask

task automatic dac_write_readback();
  logic [DAC_W-1:0]  smp [NUM_DAC];
  logic [DATA_W-1:0] sext;
  for (int i = 0; i < NUM_DAC; i++) begin
    smp[i] = DAC_W'($urandom);
    // Complement first, so the second write replaces a set register
    sext   = {{(DATA_W-DAC_W){~smp[i][DAC_W-1]}}, ~smp[i]};
    send_cmd(OP_WRITE, 16'h4000 + 16'(i), sext, 1'b0, '0);
    sext   = {{(DATA_W-DAC_W){smp[i][DAC_W-1]}}, smp[i]};
    send_cmd(OP_WRITE, 16'h4000 + 16'(i), sext, 1'b0, '0);
  end
  for (int i = 0; i < NUM_DAC; i++) begin
    sext = {{(DATA_W-DAC_W){smp[i][DAC_W-1]}}, smp[i]};
    send_cmd(OP_READ, 16'h4000 + 16'(i), '0, 1'b0, sext);
  end
  drain_rsp();
  @(negedge adc_clk);
  for (int i = 0; i < NUM_DAC; i++) begin
    check_val("dac_dat_o", dac_dat_o[i], dac_expect(smp[i]));
  end
endtask

task automatic adc_capture_read();
  logic [NUM_ADC-1:0][ADC_W-1:0] raw;
  for (int i = 0; i < NUM_ADC; i++) begin
    raw[i] = ADC_W'($urandom);
  end
  @(posedge adc_clk);
  adc_dat_i <= raw;
  repeat (2) @(posedge adc_clk);
  for (int i = 0; i < NUM_ADC; i++) begin
    send_cmd(OP_READ, 16'h8000 + 16'(i), '0, 1'b0, adc_expect(raw[i]));
  end
  drain_rsp();
endtask

task automatic pdm_density_count();
  pdm_level_t lvl [PDM_CHN];
  int         ones [PDM_CHN];
  for (int i = 0; i < PDM_CHN; i++) begin
    lvl[i] = PDM_W'($urandom);
    send_cmd(OP_WRITE, 16'h1000 + 16'(i), DATA_W'(lvl[i]), 1'b0, '0);
  end
  for (int i = 0; i < PDM_CHN; i++) begin
    send_cmd(OP_READ, 16'h1000 + 16'(i), '0, 1'b0, DATA_W'(lvl[i]));
  end
  drain_rsp();
  // Settle, then one full modulator period
  repeat (255) @(negedge adc_clk);
  for (int i = 0; i < PDM_CHN; i++) begin
    ones[i] = 0;
  end
  repeat (255) begin
    @(negedge adc_clk);
    for (int i = 0; i < PDM_CHN; i++) begin
      if (pdm_o[i]) ones[i]++;
    end
  end
  for (int i = 0; i < PDM_CHN; i++) begin
    check_val("pdm ones per period", ones[i], lvl[i]);
  end
endtask

`endif

//--- bench/tb_top.sv
//////////////////////////////////////////////////
// Testbench of the board top level
// Clock, reset, DUT, response monitor, watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_top import pitaya_pkg::*; ();

  localparam int unsigned       NUM_ADC     = 2;
  localparam int unsigned       NUM_DAC     = 2;
  localparam int unsigned       PDM_CHN     = 4;
  localparam int unsigned       CMD_CREDITS = 2;
  localparam logic [DATA_W-1:0] ID_VALUE    = 32'h5250_0001;
  // ID/errors, burst, DAC, ADC, PDM
  localparam int NUM_CMDS = 4 + CMD_CREDITS + 3 * NUM_DAC + NUM_ADC + 2 * PDM_CHN;
  localparam int WD_CYCLES = NUM_CMDS * 10 + 2000;

  logic                          adc_clk;
  logic                          top_rst;
  logic                          cmd_valid_i;
  bus_cmd_t                      cmd_i;
  logic                          credit_o;
  logic                          rsp_valid_o;
  bus_rsp_t                      rsp_o;
  logic [NUM_ADC-1:0][ADC_W-1:0] adc_dat_i;
  logic [NUM_DAC-1:0][DAC_W-1:0] dac_dat_o;
  logic [PDM_CHN-1:0]            pdm_o;

  // Host bookkeeping
  int       errors = 0;
  int       n_cmds = 0;
  int       credits = CMD_CREDITS;
  int       credit_cnt = 0;
  int       cyc = 0;
  bus_rsp_t exp_q [$];
  int       due_q [$];

  `include "tb_tasks.svh"

  pitaya_top #(
    .NUM_ADC     (NUM_ADC),
    .NUM_DAC     (NUM_DAC),
    .PDM_CHN     (PDM_CHN),
    .CMD_CREDITS (CMD_CREDITS),
    .ID_VALUE    (ID_VALUE)
  ) dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .credit_o    (credit_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .adc_dat_i   (adc_dat_i),
    .dac_dat_o   (dac_dat_o),
    .pdm_o       (pdm_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cyc <= cyc + 1;
  end

  //////////////////////////////////////////////////
  // Response monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge adc_clk) begin : monitor
    bus_rsp_t exp_rsp;
    int       due;
    if (!top_rst) begin
      // Credits seen on the pins up to the last cycle
      if (cmd_valid_i) begin
        if (credits <= 0) begin
          errors++;
          $display("Command sent with no credit left at %0t", $time);
        end
        credits--;
        // Accepted at the next edge, answer 3 edges later
        due_q.push_back(cyc + 4);
      end
      if (credit_o) begin
        credits++;
        credit_cnt++;
      end
      if (credits > CMD_CREDITS) begin
        errors++;
        $display("More credits returned than the host ever had at %0t", $time);
      end
      if (rsp_valid_o) begin
        if (exp_q.size() == 0 || due_q.size() == 0) begin
          errors++;
          $display("Response with no pending command at %0t", $time);
        end else begin
          exp_rsp = exp_q.pop_front();
          due     = due_q.pop_front();
          check_val("response", rsp_o, exp_rsp);
          check_val("response cycle", cyc, due);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge adc_clk);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hee7d));
    top_rst     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    adc_dat_i   = '0;
    repeat (5) @(posedge adc_clk);
    top_rst <= 1'b0;

    reset_state_quiet();
    id_and_error_reads();
    credit_burst_latency();
    dac_write_readback();
    adc_capture_read();
    pdm_density_count();

    $display("Errors: %0d, commands sent: %0d, credits returned: %0d",
             errors, n_cmds, credit_cnt);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
logic/pitaya_pkg.sv
logic/bus_decode.sv
logic/reg_execute.sv
logic/bus_result.sv
logic/analog_io.sv
logic/pdm_mod.sv
logic/pitaya_top.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_top -f list.f -o tb_sim \
  || { echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "Simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
